// File: source/spi_pkg.sv
package spi_pkg;

    ////////////////////////////////////////////////////////////
    // serial link shapes and timing
    ////////////////////////////////////////////////////////////

    // frame word, first bit on the wire sits in bit 31
    typedef logic [31:0] frame_t;

    // bits per frame, 1 to 32
    typedef logic [5:0] frame_len_t;

    // system clocks per half SCLK period
    localparam int SCLK_HALF = 4;

    // cs_n low to first SCLK edge, last SCLK edge to cs_n high
    localparam int CS_SETUP = 4;
    localparam int CS_HOLD  = 4;

    // idle clocks between two frames
    localparam int FRAME_GAP = 24;

    typedef logic [$clog2(FRAME_GAP + 1)-1:0] gap_cnt_t;

endpackage

// File: source/ad7124_pkg.sv
package ad7124_pkg;

    ////////////////////////////////////////////////////////////
    // register map of the AD7124 as used by this controller
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  cmd_t;
    typedef logic [23:0] sample_t;

    // comms byte, bit 6 selects read, low six bits the register
    localparam cmd_t CMD_WR_ADC_CONTROL  = 8'h01;
    localparam cmd_t CMD_WR_IO_CONTROL_1 = 8'h03;
    localparam cmd_t CMD_WR_CHANNEL_0    = 8'h09;
    localparam cmd_t CMD_WR_CONFIG_0     = 8'h19;
    localparam cmd_t CMD_WR_FILTER_0     = 8'h21;
    localparam cmd_t CMD_READ_STATUS     = 8'h40;
    localparam cmd_t CMD_READ_DATA       = 8'h42;

    localparam int NUM_CFG_WRITES = 5;

    // setup frames, MSB first, padded on the right to 32 bits
    localparam logic [31:0] CFG_WORD_0 = {CMD_WR_ADC_CONTROL, 16'h0080, 8'h00};
    localparam logic [31:0] CFG_WORD_1 = {CMD_WR_IO_CONTROL_1, 24'h0018C0};
    localparam logic [31:0] CFG_WORD_2 = {CMD_WR_CHANNEL_0, 16'h81CF, 8'h00};
    localparam logic [31:0] CFG_WORD_3 = {CMD_WR_CONFIG_0, 16'h09E1, 8'h00};
    localparam logic [31:0] CFG_WORD_4 = {CMD_WR_FILTER_0, 24'h0603C0};

    // 16 bit registers take 24 clocks, 24 bit registers 32
    localparam logic [5:0] CFG_LEN_0 = 6'd24;
    localparam logic [5:0] CFG_LEN_1 = 6'd32;
    localparam logic [5:0] CFG_LEN_2 = 6'd24;
    localparam logic [5:0] CFG_LEN_3 = 6'd24;
    localparam logic [5:0] CFG_LEN_4 = 6'd32;

    localparam logic [5:0] STATUS_LEN = 6'd16;
    localparam logic [5:0] DATA_LEN   = 6'd32;

    // RDY_N inside the status byte, low means conversion ready
    localparam int STATUS_RDY_N_BIT = 7;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_GAP,
        SEQ_CONFIG,
        SEQ_POLL,
        SEQ_READ,
        SEQ_FINISH,
        SEQ_HOLD
    } seq_state_t;

endpackage

// File: source/spi_frame_if.sv
`timescale 1ns/1ps

interface spi_frame_if;

    // request side, valid/ready handshake
    logic                req_valid;
    logic                req_ready;
    spi_pkg::frame_t     tx_word;
    spi_pkg::frame_len_t tx_len;

    // response side, single pulse when cs_n rises
    spi_pkg::frame_t     rx_word;
    logic                rx_valid;

    modport seq (
        output req_valid,
        output tx_word,
        output tx_len,
        input  req_ready,
        input  rx_word,
        input  rx_valid
    );

    modport master (
        input  req_valid,
        input  tx_word,
        input  tx_len,
        output req_ready,
        output rx_word,
        output rx_valid
    );

endinterface

// File: source/spi_frame_master.sv
`timescale 1ns/1ps

module spi_frame_master (
    input  logic        PL_clk,
    input  logic        rst,
    spi_frame_if.master bus,
    input  logic        sdo,
    output logic        cs_n,
    output logic        sclk,
    output logic        sdi
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_SETUP,
        M_LOW,
        M_HIGH,
        M_HOLD
    } master_state_t;

    master_state_t       state;
    logic [3:0]          tick;
    spi_pkg::frame_len_t bits_left;
    spi_pkg::frame_t     tx_sh;
    spi_pkg::frame_t     rx_sh;
    logic                accept;
    logic                tick_done;
    logic                fall_edge;
    logic                rise_edge;

    assign bus.req_ready = (state == M_IDLE);
    assign accept        = bus.req_valid && bus.req_ready;
    assign tick_done     = (tick == '0);

    // SCLK falls after setup and after every high phase but the last
    assign fall_edge = tick_done && ((state == M_SETUP) ||
                       ((state == M_HIGH) && (bits_left != 'd1)));
    assign rise_edge = tick_done && (state == M_LOW);

    // received bits, right aligned, cleared at accept
    assign bus.rx_word = rx_sh;

    ////////////////////////////////////////////////////////////
    // framing and clock generation
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            state        <= M_IDLE;
            tick         <= '0;
            bits_left    <= '0;
            cs_n         <= 1'b1;
            sclk         <= 1'b1;
            sdi          <= 1'b1;
            bus.rx_valid <= 1'b0;
        end else begin
            bus.rx_valid <= 1'b0;
            // new bit on the wire with every falling SCLK
            if (fall_edge) begin
                sdi <= tx_sh[31];
            end
            case (state)
                M_IDLE: begin
                    if (accept) begin
                        state     <= M_SETUP;
                        cs_n      <= 1'b0;
                        tick      <= 4'(spi_pkg::CS_SETUP - 1);
                        bits_left <= bus.tx_len;
                    end
                end
                M_SETUP: begin
                    if (tick_done) begin
                        state <= M_LOW;
                        sclk  <= 1'b0;
                        tick  <= 4'(spi_pkg::SCLK_HALF - 1);
                    end else begin
                        tick <= tick - 1'b1;
                    end
                end
                M_LOW: begin
                    if (tick_done) begin
                        state <= M_HIGH;
                        sclk  <= 1'b1;
                        tick  <= 4'(spi_pkg::SCLK_HALF - 1);
                    end else begin
                        tick <= tick - 1'b1;
                    end
                end
                M_HIGH: begin
                    if (tick_done) begin
                        bits_left <= bits_left - 1'b1;
                        if (bits_left == 'd1) begin
                            // last bit done, SCLK stays high
                            state <= M_HOLD;
                            tick  <= 4'(spi_pkg::CS_HOLD - 1);
                        end else begin
                            state <= M_LOW;
                            sclk  <= 1'b0;
                            tick  <= 4'(spi_pkg::SCLK_HALF - 1);
                        end
                    end else begin
                        tick <= tick - 1'b1;
                    end
                end
                M_HOLD: begin
                    if (tick_done) begin
                        state        <= M_IDLE;
                        cs_n         <= 1'b1;
                        bus.rx_valid <= 1'b1;
                    end else begin
                        tick <= tick - 1'b1;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // shift registers, tx moves on falling SCLK, rx samples on rising
    always_ff @(posedge PL_clk) begin
        if (accept) begin
            tx_sh <= bus.tx_word;
            rx_sh <= '0;
        end else begin
            if (fall_edge) begin
                tx_sh <= {tx_sh[30:0], 1'b0};
            end
            if (rise_edge) begin
                rx_sh <= {rx_sh[30:0], sdo};
            end
        end
    end

endmodule

// File: source/ad7124_sequencer.sv
`timescale 1ns/1ps

module ad7124_sequencer (
    input  logic                PL_clk,
    input  logic                rst,
    input  logic                start,
    spi_frame_if.seq            bus,
    output ad7124_pkg::sample_t sample,
    output logic                sample_valid,
    output logic                done
);

    ad7124_pkg::seq_state_t state;
    ad7124_pkg::seq_state_t next_phase;
    spi_pkg::gap_cnt_t      gap_cnt;
    logic [2:0]             cfg_idx;
    ad7124_pkg::cmd_t       rd_cmd;
    logic                   accept;
    logic                   status_ready;
    logic                   last_cfg;

    assign accept       = bus.req_valid && bus.req_ready;
    // status byte sits in the low eight bits of a 16 bit frame
    assign status_ready = !bus.rx_word[ad7124_pkg::STATUS_RDY_N_BIT];
    assign last_cfg     = (cfg_idx == 3'(ad7124_pkg::NUM_CFG_WRITES - 1));

    ////////////////////////////////////////////////////////////
    // frame contents, stable for as long as the state holds
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_cmd = (state == ad7124_pkg::SEQ_READ) ? ad7124_pkg::CMD_READ_DATA
                                                 : ad7124_pkg::CMD_READ_STATUS;
        bus.tx_word = {rd_cmd, 24'h000000};
        bus.tx_len  = (state == ad7124_pkg::SEQ_READ) ? ad7124_pkg::DATA_LEN
                                                      : ad7124_pkg::STATUS_LEN;
        if (state == ad7124_pkg::SEQ_CONFIG) begin
            case (cfg_idx)
                3'd0: begin
                    bus.tx_word = ad7124_pkg::CFG_WORD_0;
                    bus.tx_len  = ad7124_pkg::CFG_LEN_0;
                end
                3'd1: begin
                    bus.tx_word = ad7124_pkg::CFG_WORD_1;
                    bus.tx_len  = ad7124_pkg::CFG_LEN_1;
                end
                3'd2: begin
                    bus.tx_word = ad7124_pkg::CFG_WORD_2;
                    bus.tx_len  = ad7124_pkg::CFG_LEN_2;
                end
                3'd3: begin
                    bus.tx_word = ad7124_pkg::CFG_WORD_3;
                    bus.tx_len  = ad7124_pkg::CFG_LEN_3;
                end
                default: begin
                    bus.tx_word = ad7124_pkg::CFG_WORD_4;
                    bus.tx_len  = ad7124_pkg::CFG_LEN_4;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // acquisition FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            state         <= ad7124_pkg::SEQ_IDLE;
            next_phase    <= ad7124_pkg::SEQ_CONFIG;
            gap_cnt       <= '0;
            cfg_idx       <= '0;
            bus.req_valid <= 1'b0;
            sample_valid  <= 1'b0;
            done          <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            // engine is idle whenever we ask, so accept comes at once
            if (accept) begin
                bus.req_valid <= 1'b0;
            end
            case (state)
                ad7124_pkg::SEQ_IDLE: begin
                    if (start) begin
                        state      <= ad7124_pkg::SEQ_GAP;
                        next_phase <= ad7124_pkg::SEQ_CONFIG;
                        cfg_idx    <= '0;
                        gap_cnt    <= spi_pkg::gap_cnt_t'(spi_pkg::FRAME_GAP - 1);
                    end
                end
                ad7124_pkg::SEQ_GAP: begin
                    if (!start) begin
                        state <= ad7124_pkg::SEQ_IDLE;
                    end else if (gap_cnt == '0) begin
                        state         <= next_phase;
                        bus.req_valid <= 1'b1;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                ad7124_pkg::SEQ_CONFIG: begin
                    if (bus.rx_valid) begin
                        state   <= start ? ad7124_pkg::SEQ_GAP : ad7124_pkg::SEQ_IDLE;
                        gap_cnt <= spi_pkg::gap_cnt_t'(spi_pkg::FRAME_GAP - 1);
                        if (last_cfg) begin
                            next_phase <= ad7124_pkg::SEQ_POLL;
                        end else begin
                            next_phase <= ad7124_pkg::SEQ_CONFIG;
                            cfg_idx    <= cfg_idx + 3'd1;
                        end
                    end
                end
                ad7124_pkg::SEQ_POLL: begin
                    // poll again until RDY_N reads low
                    if (bus.rx_valid) begin
                        state      <= start ? ad7124_pkg::SEQ_GAP : ad7124_pkg::SEQ_IDLE;
                        gap_cnt    <= spi_pkg::gap_cnt_t'(spi_pkg::FRAME_GAP - 1);
                        next_phase <= status_ready ? ad7124_pkg::SEQ_READ
                                                   : ad7124_pkg::SEQ_POLL;
                    end
                end
                ad7124_pkg::SEQ_READ: begin
                    if (bus.rx_valid) begin
                        if (start) begin
                            sample_valid <= 1'b1;
                            state        <= ad7124_pkg::SEQ_FINISH;
                        end else begin
                            state <= ad7124_pkg::SEQ_IDLE;
                        end
                    end
                end
                ad7124_pkg::SEQ_FINISH: begin
                    done  <= 1'b1;
                    state <= ad7124_pkg::SEQ_HOLD;
                end
                ad7124_pkg::SEQ_HOLD: begin
                    // single shot, wait here until start drops
                    if (!start) begin
                        done  <= 1'b0;
                        state <= ad7124_pkg::SEQ_IDLE;
                    end
                end
                default: state <= ad7124_pkg::SEQ_IDLE;
            endcase
        end
    end

    // low 24 bits of the data frame are the conversion result
    always_ff @(posedge PL_clk) begin
        if ((state == ad7124_pkg::SEQ_READ) && bus.rx_valid) begin
            sample <= bus.rx_word[23:0];
        end
    end

endmodule

// File: source/ad7124_ctrl.sv
`timescale 1ns/1ps

module ad7124_ctrl (
    input  logic                PL_clk,
    input  logic                rst,
    input  logic                start,
    input  logic                tc_sdo,
    output logic                tc_cs_n,
    output logic                tc_sclk,
    output logic                tc_sdi,
    output ad7124_pkg::sample_t sample,
    output logic                sample_valid,
    output logic                done
);

    ////////////////////////////////////////////////////////////
    // sequencer to frame engine link
    ////////////////////////////////////////////////////////////

    spi_frame_if frame_bus ();

    // register writes, status polls, data read
    ad7124_sequencer seq0 (
        .PL_clk       (PL_clk),
        .rst          (rst),
        .start        (start),
        .bus          (frame_bus.seq),
        .sample       (sample),
        .sample_valid (sample_valid),
        .done         (done)
    );

    // one mode 3 SPI frame per request
    spi_frame_master spi0 (
        .PL_clk (PL_clk),
        .rst    (rst),
        .bus    (frame_bus.master),
        .sdo    (tc_sdo),
        .cs_n   (tc_cs_n),
        .sclk   (tc_sclk),
        .sdi    (tc_sdi)
    );

endmodule

// File: tb/ad7124_sva_checker.sv
`timescale 1ns/1ps

module ad7124_sva_checker (
    input logic PL_clk,
    input logic rst,
    input logic tc_cs_n,
    input logic tc_sclk,
    input logic tc_sdi,
    input logic sample_valid,
    input logic done
);

    int failures = 0;

    // mode 3, SCLK parks high outside a frame
    idle_clock_high: assert property (@(posedge PL_clk) tc_cs_n |-> tc_sclk)
        else begin
            $error("tc_sclk low while tc_cs_n is high");
            failures++;
        end

    // data only moves on the falling edge
    sdi_stable_high: assert property (@(posedge PL_clk) disable iff (!rst)
        (!tc_cs_n && tc_sclk) |-> $stable(tc_sdi))
        else begin
            $error("tc_sdi changed while tc_sclk is high in a frame");
            failures++;
        end

    reset_values: assert property (@(posedge PL_clk)
        !rst |-> (tc_cs_n && !sample_valid && !done))
        else begin
            $error("outputs left their reset values while rst is low");
            failures++;
        end

    valid_one_cycle: assert property (@(posedge PL_clk) disable iff (!rst)
        sample_valid |=> !sample_valid)
        else begin
            $error("sample_valid high for two cycles");
            failures++;
        end

endmodule

bind ad7124_ctrl ad7124_sva_checker sva0 (
    .PL_clk       (PL_clk),
    .rst          (rst),
    .tc_cs_n      (tc_cs_n),
    .tc_sclk      (tc_sclk),
    .tc_sdi       (tc_sdi),
    .sample_valid (sample_valid),
    .done         (done)
);

// File: tb/ad7124_scoreboard.sv
`timescale 1ns/1ps

module ad7124_scoreboard (
    input  logic                PL_clk,
    input  logic                rst,
    input  logic                start,
    input  logic                tc_cs_n,
    input  logic                tc_sclk,
    input  logic                tc_sdi,
    input  ad7124_pkg::sample_t sample,
    input  logic                sample_valid,
    input  logic                done,
    input  int                  exp_polls,
    input  ad7124_pkg::sample_t exp_data,
    output int                  errors,
    output int                  frames,
    output int                  samples
);

    logic        cs_q;
    logic        sclk_q;
    logic        start_q;
    logic        done_q;
    logic [31:0] shift;
    logic [31:0] word;
    logic [37:0] expected;
    int          bit_cnt;
    int          frame_idx;
    int          run_samples;

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // {length, left aligned word} of frame idx within a run
    function automatic logic [37:0] expected_frame(input int idx, input int polls);
        case (idx)
            0: return {6'd24, 32'h0100_8000};
            1: return {6'd32, 32'h0300_18C0};
            2: return {6'd24, 32'h0981_CF00};
            3: return {6'd24, 32'h1909_E100};
            4: return {6'd32, 32'h2106_03C0};
            default: begin
                if (idx <= 5 + polls) begin
                    return {6'd16, 32'h4000_0000};
                end
                if (idx == 6 + polls) begin
                    return {6'd32, 32'h4200_0000};
                end
                // nothing may follow the data read
                return '0;
            end
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // pin decode, sampled once per clock
    ////////////////////////////////////////////////////////////

    always @(posedge PL_clk) begin
        if (!rst) begin
            cs_q        = 1'b1;
            sclk_q      = 1'b1;
            start_q     = 1'b0;
            done_q      = 1'b0;
            shift       = '0;
            bit_cnt     = 0;
            frame_idx   = 0;
            run_samples = 0;
            errors      = 0;
            frames      = 0;
            samples     = 0;
        end else begin
            if (start && !start_q) begin
                frame_idx   = 0;
                run_samples = 0;
            end
            if (cs_q && !tc_cs_n) begin
                bit_cnt = 0;
                shift   = '0;
                if (done) begin
                    report_mismatch("frame started while done is high");
                end
            end
            // sdi is taken on rising SCLK
            if (!tc_cs_n && !sclk_q && tc_sclk) begin
                shift = {shift[30:0], tc_sdi};
                bit_cnt++;
            end
            if (!cs_q && tc_cs_n) begin
                word     = (bit_cnt > 0) ? (shift << (32 - bit_cnt)) : 32'h0;
                expected = expected_frame(frame_idx, exp_polls);
                if ({6'(bit_cnt), word} !== expected) begin
                    report_mismatch($sformatf("frame %0d: %0d bits %h, expected %0d bits %h",
                        frame_idx, bit_cnt, word, expected[37:32], expected[31:0]));
                end
                frame_idx++;
                frames++;
            end
            if (sample_valid) begin
                samples++;
                run_samples++;
                if (sample !== exp_data) begin
                    report_mismatch($sformatf("sample %h, expected %h", sample, exp_data));
                end
                if (frame_idx != exp_polls + 7 || run_samples > 1) begin
                    report_mismatch("sample_valid out of place in the frame sequence");
                end
            end
            if (done && !done_q && run_samples != 1) begin
                report_mismatch($sformatf("done rose after %0d samples", run_samples));
            end
            if (!done && done_q && start) begin
                report_mismatch("done fell while start is high");
            end
            cs_q    = tc_cs_n;
            sclk_q  = tc_sclk;
            start_q = start;
            done_q  = done;
        end
    end

endmodule

// File: tb/tb_ad7124.sv
`timescale 1ns/1ps

module tb_ad7124;

    localparam int NUM_RUNS    = 8;
    // runs x frames per run x worst frame with gap, doubled for margin
    localparam int CYCLE_LIMIT = NUM_RUNS * 10 * (32 * 2 * spi_pkg::SCLK_HALF +
        spi_pkg::CS_SETUP + spi_pkg::CS_HOLD + spi_pkg::FRAME_GAP + 8) * 2;

    logic                PL_clk;
    logic                rst;
    logic                start;
    logic                tc_sdo;
    logic                tc_cs_n;
    logic                tc_sclk;
    logic                tc_sdi;
    ad7124_pkg::sample_t sample;
    logic                sample_valid;
    logic                done;

    logic [31:0]         rng;
    int                  exp_polls;
    ad7124_pkg::sample_t exp_data;
    int                  run_id;
    int                  low_cycles;
    int                  cycle_cnt = 0;
    int                  sb_errors;
    int                  sb_frames;
    int                  sb_samples;

    ad7124_ctrl dut0 (
        .PL_clk       (PL_clk),
        .rst          (rst),
        .start        (start),
        .tc_sdo       (tc_sdo),
        .tc_cs_n      (tc_cs_n),
        .tc_sclk      (tc_sclk),
        .tc_sdi       (tc_sdi),
        .sample       (sample),
        .sample_valid (sample_valid),
        .done         (done)
    );

    ad7124_scoreboard scoreboard0 (
        .PL_clk       (PL_clk),
        .rst          (rst),
        .start        (start),
        .tc_cs_n      (tc_cs_n),
        .tc_sclk      (tc_sclk),
        .tc_sdi       (tc_sdi),
        .sample       (sample),
        .sample_valid (sample_valid),
        .done         (done),
        .exp_polls    (exp_polls),
        .exp_data     (exp_data),
        .errors       (sb_errors),
        .frames       (sb_frames),
        .samples      (sb_samples)
    );

    // 32 bit xorshift, shifts 13/17/5
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        PL_clk = 1'b0;
        forever #10 PL_clk = ~PL_clk;
    end

    always @(posedge PL_clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: sequence not finished after %0d clock cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // ADC model on tc_sdo
    ////////////////////////////////////////////////////////////

    initial begin : adc_model
        logic             cs_q;
        logic             sclk_q;
        int               bit_cnt;
        int               model_run;
        int               polls_served;
        ad7124_pkg::cmd_t cmd_rx;
        logic [31:0]      reply;
        tc_sdo       = 1'b1;
        cs_q         = 1'b1;
        sclk_q       = 1'b1;
        bit_cnt      = 0;
        model_run    = 0;
        polls_served = 0;
        cmd_rx       = '0;
        reply        = '0;
        forever begin
            @(tc_cs_n or tc_sclk);
            if (cs_q && !tc_cs_n) begin
                // first frame of a new run clears the poll count
                if (model_run != run_id) begin
                    model_run    = run_id;
                    polls_served = 0;
                end
                bit_cnt = 0;
                cmd_rx  = '0;
            end else if (!cs_q && tc_cs_n) begin
                if (cmd_rx == 8'h40) begin
                    polls_served++;
                end
            end else if (!tc_cs_n && !sclk_q && tc_sclk) begin
                // command byte arrives MSB first
                if (bit_cnt < 8) begin
                    cmd_rx = {cmd_rx[6:0], tc_sdi};
                end
                bit_cnt++;
            end else if (!tc_cs_n && sclk_q && !tc_sclk && bit_cnt >= 8) begin
                if (cmd_rx == 8'h40) begin
                    // RDY_N stays set until the chosen number of polls has passed
                    reply = {polls_served < exp_polls, exp_data[6:0], 24'h000000};
                end else if (cmd_rx == 8'h42) begin
                    reply = {exp_data, 8'h00};
                end else begin
                    reply = '0;
                end
                #2 tc_sdo = reply[5'(31 - (bit_cnt - 8))];
            end
            cs_q   = tc_cs_n;
            sclk_q = tc_sclk;
        end
    end

    ////////////////////////////////////////////////////////////
    // runs
    ////////////////////////////////////////////////////////////

    initial begin : main_flow
        rst        = 1'b1;
        start      = 1'b0;
        rng        = 32'hb78d;
        exp_polls  = 0;
        exp_data   = '0;
        run_id     = 0;
        low_cycles = 0;
        // a real falling edge on rst, ahead of the first clock
        #1 rst = 1'b0;
        repeat (10) @(posedge PL_clk);
        #2 rst = 1'b1;
        for (run_id = 1; run_id <= NUM_RUNS; run_id++) begin
            rng        = next_random(rng);
            exp_polls  = int'(rng[1:0]);
            rng        = next_random(rng);
            exp_data   = rng[23:0];
            rng        = next_random(rng);
            low_cycles = 4 + int'(rng[5:0]);
            @(posedge PL_clk);
            #2 start = 1'b1;
            do @(posedge PL_clk); while (!done);
            // start stays high a while, a stray frame would show here
            repeat (3 * spi_pkg::FRAME_GAP) @(posedge PL_clk);
            #2 start = 1'b0;
            do @(posedge PL_clk); while (done);
            repeat (low_cycles) @(posedge PL_clk);
        end
        repeat (5) @(posedge PL_clk);
        $display("closing counts: frames %0d, samples %0d, check errors %0d, assertion failures %0d",
                 sb_frames, sb_samples, sb_errors, dut0.sva0.failures);
        if (sb_errors == 0 && dut0.sva0.failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: project.f
source/spi_pkg.sv
source/ad7124_pkg.sv
source/spi_frame_if.sv
source/spi_frame_master.sv
source/ad7124_sequencer.sv
source/ad7124_ctrl.sv
tb/ad7124_sva_checker.sv
tb/ad7124_scoreboard.sv
tb/tb_ad7124.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ad7124
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
